// ==== logic/tracker_pkg.sv ====
package tracker_pkg;

    // pixel and raster widths
    localparam int COLOR_W = 8;               // one colour channel
    localparam int PIXEL_W = 3 * COLOR_W;     // r/y on top, then g/cr, then b/cb
    localparam int X_W     = 11;              // horizontal count
    localparam int Y_W     = 10;              // vertical count

    // coordinate sums, mask count and divider iterations all share this
    localparam int SUM_W   = 32;

    // channel select codes, 3'b011 and 3'b111 give zero
    localparam logic [2:0] SEL_GREEN = 3'b000;
    localparam logic [2:0] SEL_RED   = 3'b001;
    localparam logic [2:0] SEL_BLUE  = 3'b010;
    localparam logic [2:0] SEL_Y     = 3'b100;
    localparam logic [2:0] SEL_CR    = 3'b101;
    localparam logic [2:0] SEL_CB    = 3'b110;

    // background choice for the output pixel
    localparam logic [1:0] BG_CAMERA    = 2'b00;  // camera image as is
    localparam logic [1:0] BG_CHANNEL   = 2'b01;  // selected channel in grey
    localparam logic [1:0] BG_MASK      = 2'b10;  // white where masked
    localparam logic [1:0] BG_MASK_OVER = 2'b11;  // grey channel, magenta mask

    localparam logic [PIXEL_W-1:0] MAGENTA = 24'hFF00FF;  // full red and blue

endpackage

// ==== logic/video_timing.sv ====
`timescale 1ns/1ps

module video_timing #(
    parameter int H_ACTIVE = 1280,
    parameter int H_FP     = 110,
    parameter int H_SYNC   = 40,
    parameter int H_BP     = 220,
    parameter int V_ACTIVE = 720,
    parameter int V_FP     = 5,
    parameter int V_SYNC   = 5,
    parameter int V_BP     = 20
) (
    input  logic                      clk_pixel,
    input  logic                      recent_reset,
    output logic [tracker_pkg::X_W-1:0] hcount,
    output logic [tracker_pkg::Y_W-1:0] vcount,
    output logic                      hsync,
    output logic                      vsync,
    output logic                      active_draw,
    output logic                      new_frame
);
    import tracker_pkg::*;

    localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;  // cycles per line
    localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;  // lines per frame

    logic [X_W-1:0] h_next;
    logic [Y_W-1:0] v_next;
    logic           line_end;

    // next raster position, decodes below are taken from it so the
    // registered flags line up with the registered counts
    assign line_end = (hcount == X_W'(H_TOTAL - 1));

    always_comb begin
        h_next = line_end ? '0 : hcount + 1'b1;
        v_next = vcount;
        if (line_end) begin
            v_next = (vcount == Y_W'(V_TOTAL - 1)) ? '0 : vcount + 1'b1;  // wrap at frame end
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            hcount      <= '0;
            vcount      <= '0;
            hsync       <= 1'b0;
            vsync       <= 1'b0;
            active_draw <= 1'b0;
            new_frame   <= 1'b0;
        end else begin
            hcount      <= h_next;
            vcount      <= v_next;
            hsync       <= (h_next >= H_ACTIVE + H_FP) && (h_next < H_ACTIVE + H_FP + H_SYNC);
            vsync       <= (v_next >= V_ACTIVE + V_FP) && (v_next < V_ACTIVE + V_FP + V_SYNC);
            active_draw <= (h_next < H_ACTIVE) && (v_next < V_ACTIVE);
            new_frame   <= (h_next == '0) && (v_next == Y_W'(V_ACTIVE));  // first blank line
        end
    end

endmodule

// ==== logic/channel_mask.sv ====
`timescale 1ns/1ps

module channel_mask (
    input  logic                          clk_pixel,
    input  logic                          recent_reset,
    input  logic [tracker_pkg::X_W-1:0]     hcount,
    input  logic [tracker_pkg::Y_W-1:0]     vcount,
    input  logic                          hsync,
    input  logic                          vsync,
    input  logic                          active_draw,
    input  logic                          new_frame,
    input  logic [tracker_pkg::PIXEL_W-1:0] pixel_rgb,
    input  logic [tracker_pkg::PIXEL_W-1:0] pixel_ycc,
    input  logic [2:0]                    channel_sel,
    input  logic [3:0]                    lower_nib,
    input  logic [3:0]                    upper_nib,
    output logic [tracker_pkg::X_W-1:0]     s2_hcount,
    output logic [tracker_pkg::Y_W-1:0]     s2_vcount,
    output logic                          s2_hsync,
    output logic                          s2_vsync,
    output logic                          s2_active_draw,
    output logic                          s2_new_frame,
    output logic [tracker_pkg::PIXEL_W-1:0] s2_rgb,
    output logic [tracker_pkg::COLOR_W-1:0] s2_channel,
    output logic                          s2_mask
);
    import tracker_pkg::*;

    logic [COLOR_W-1:0] chan_sel;                       // decoded channel, combinational
    logic [X_W-1:0]     s1_hcount;
    logic [Y_W-1:0]     s1_vcount;
    logic               s1_hsync, s1_vsync, s1_active_draw, s1_new_frame;
    logic [PIXEL_W-1:0] s1_rgb;
    logic [COLOR_W-1:0] s1_channel;
    logic [COLOR_W-1:0] s1_lower, s1_upper;            // bounds, nibble then four zeros

    always_comb begin
        case (channel_sel)
            SEL_GREEN: chan_sel = pixel_rgb[15:8];
            SEL_RED:   chan_sel = pixel_rgb[23:16];
            SEL_BLUE:  chan_sel = pixel_rgb[7:0];
            SEL_Y:     chan_sel = pixel_ycc[23:16];
            SEL_CR:    chan_sel = pixel_ycc[15:8];
            SEL_CB:    chan_sel = pixel_ycc[7:0];
            default:   chan_sel = '0;                  // invalid codes read as black
        endcase
    end

    // stage 1: channel byte, bounds and raster context
    always_ff @(posedge clk_pixel) begin
        s1_rgb     <= pixel_rgb;
        s1_channel <= chan_sel;
        s1_lower   <= {lower_nib, 4'b0000};
        s1_upper   <= {upper_nib, 4'b0000};
        if (recent_reset) begin
            {s1_hcount, s1_vcount} <= '0;
            {s1_hsync, s1_vsync, s1_active_draw, s1_new_frame} <= '0;
        end else begin
            {s1_hcount, s1_vcount} <= {hcount, vcount};
            {s1_hsync, s1_vsync, s1_active_draw, s1_new_frame} <=
                {hsync, vsync, active_draw, new_frame};
        end
    end

    // stage 2: inclusive threshold, context rides along
    always_ff @(posedge clk_pixel) begin
        s2_rgb     <= s1_rgb;
        s2_channel <= s1_channel;
        if (recent_reset) begin
            {s2_hcount, s2_vcount} <= '0;
            {s2_hsync, s2_vsync, s2_active_draw, s2_new_frame} <= '0;
            s2_mask <= 1'b0;
        end else begin
            {s2_hcount, s2_vcount} <= {s1_hcount, s1_vcount};
            {s2_hsync, s2_vsync, s2_active_draw, s2_new_frame} <=
                {s1_hsync, s1_vsync, s1_active_draw, s1_new_frame};
            s2_mask <= (s1_channel >= s1_lower) && (s1_channel <= s1_upper);
        end
    end

endmodule

// ==== logic/centroid.sv ====
`timescale 1ns/1ps

module centroid #(
    parameter int H_ACTIVE = 1280,
    parameter int V_ACTIVE = 720
) (
    input  logic                      clk_pixel,
    input  logic                      recent_reset,
    input  logic [tracker_pkg::X_W-1:0] x_in,
    input  logic [tracker_pkg::Y_W-1:0] y_in,
    input  logic                      active_draw,
    input  logic                      mask,
    input  logic                      tally,         // end of frame, stage-2 new_frame
    output logic [tracker_pkg::X_W-1:0] x_com,
    output logic [tracker_pkg::Y_W-1:0] y_com,
    output logic                      com_valid
);
    import tracker_pkg::*;

    localparam int ITER_W = $clog2(SUM_W);

    logic [SUM_W-1:0]   x_acc, y_acc, n_acc;  // running sums over the frame
    logic [SUM_W-1:0]   x_quo, y_quo;         // dividend shifting out, quotient shifting in
    logic [SUM_W-1:0]   x_rem, y_rem;         // partial remainders
    logic [SUM_W-1:0]   den;                  // mask pixel count of the latched frame
    logic [2*SUM_W-1:0] x_step, y_step;       // {rem, quo} after one iteration
    logic [ITER_W-1:0]  iter;
    logic               busy;
    logic               take;
    logic               start;

    // one restoring step, bring in the next dividend bit and try to subtract
    function automatic logic [2*SUM_W-1:0] div_step(
        input logic [SUM_W-1:0] rem,
        input logic [SUM_W-1:0] quo,
        input logic [SUM_W-1:0] dv
    );
        logic [SUM_W:0] trial;
        logic [SUM_W:0] diff;
        trial = {rem, quo[SUM_W-1]};
        diff  = trial - {1'b0, dv};
        if (trial >= {1'b0, dv}) begin
            return {diff[SUM_W-1:0], quo[SUM_W-2:0], 1'b1};
        end
        return {trial[SUM_W-1:0], quo[SUM_W-2:0], 1'b0};  // restore
    endfunction

    assign take  = active_draw && mask && (x_in < H_ACTIVE) && (y_in < V_ACTIVE);
    assign start = tally && !busy;            // tally during a division is dropped

    always_comb begin
        x_step = div_step(x_rem, x_quo, den);
        y_step = div_step(y_rem, y_quo, den);  // same divisor, both run side by side
    end

    // control: accumulators, divider sequencing, held result
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            x_acc     <= '0;
            y_acc     <= '0;
            n_acc     <= '0;
            busy      <= 1'b0;
            iter      <= '0;
            com_valid <= 1'b0;
            x_com     <= '0;
            y_com     <= '0;
        end else begin
            com_valid <= 1'b0;
            if (start) begin
                x_acc <= '0;
                y_acc <= '0;
                n_acc <= '0;
                busy  <= (n_acc != '0);       // empty frame keeps the old centre
                iter  <= '0;
            end else if (take) begin
                x_acc <= x_acc + SUM_W'(x_in);
                y_acc <= y_acc + SUM_W'(y_in);
                n_acc <= n_acc + 1'b1;
            end
            if (busy) begin
                iter <= iter + 1'b1;
                if (iter == ITER_W'(SUM_W - 1)) begin  // last of SUM_W steps
                    busy      <= 1'b0;
                    x_com     <= x_step[X_W-1:0];
                    y_com     <= y_step[Y_W-1:0];
                    com_valid <= 1'b1;
                end
            end
        end
    end

    // datapath
    always_ff @(posedge clk_pixel) begin
        if (start) begin
            x_quo <= x_acc;
            y_quo <= y_acc;
            x_rem <= '0;
            y_rem <= '0;
            den   <= n_acc;
        end else if (busy) begin
            {x_rem, x_quo} <= x_step;
            {y_rem, y_quo} <= y_step;
        end
    end

endmodule

// ==== logic/overlay_mux.sv ====
`timescale 1ns/1ps

module overlay_mux (
    input  logic                          clk_pixel,
    input  logic                          recent_reset,
    input  logic [tracker_pkg::X_W-1:0]     s2_hcount,
    input  logic [tracker_pkg::Y_W-1:0]     s2_vcount,
    input  logic                          s2_hsync,
    input  logic                          s2_vsync,
    input  logic                          s2_active_draw,
    input  logic [tracker_pkg::PIXEL_W-1:0] s2_rgb,
    input  logic [tracker_pkg::COLOR_W-1:0] s2_channel,
    input  logic                          s2_mask,
    input  logic [tracker_pkg::X_W-1:0]     x_com,
    input  logic [tracker_pkg::Y_W-1:0]     y_com,
    input  logic [1:0]                    bg_sel,
    input  logic                          crosshair_en,
    output logic [tracker_pkg::X_W-1:0]     hcount_out,
    output logic [tracker_pkg::Y_W-1:0]     vcount_out,
    output logic                          hsync_out,
    output logic                          vsync_out,
    output logic                          active_draw_out,
    output logic [tracker_pkg::PIXEL_W-1:0] pixel_out
);
    import tracker_pkg::*;

    logic [PIXEL_W-1:0] grey;      // channel byte copied to r, g and b
    logic [PIXEL_W-1:0] bg_pix;
    logic [PIXEL_W-1:0] mix_pix;
    logic               on_cross;

    assign grey     = {3{s2_channel}};
    assign on_cross = crosshair_en && ((s2_hcount == x_com) || (s2_vcount == y_com));

    always_comb begin
        case (bg_sel)
            BG_CAMERA:  bg_pix = s2_rgb;
            BG_CHANNEL: bg_pix = grey;
            BG_MASK:    bg_pix = s2_mask ? {PIXEL_W{1'b1}} : '0;
            default:    bg_pix = s2_mask ? MAGENTA : grey;      // BG_MASK_OVER
        endcase
        mix_pix = on_cross ? {PIXEL_W{1'b1}} : bg_pix;       // white crosshair on top
        if (!s2_active_draw) begin
            mix_pix = '0;                                      // blank outside the picture
        end
    end

    // output register, t+3 relative to the raster counter
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            {hcount_out, vcount_out} <= '0;
            {hsync_out, vsync_out, active_draw_out} <= '0;
            pixel_out <= '0;
        end else begin
            {hcount_out, vcount_out} <= {s2_hcount, s2_vcount};
            {hsync_out, vsync_out, active_draw_out} <= {s2_hsync, s2_vsync, s2_active_draw};
            pixel_out <= mix_pix;
        end
    end

endmodule

// ==== logic/tracker_top.sv ====
`timescale 1ns/1ps

module tracker_top #(
    parameter int H_ACTIVE = 1280,
    parameter int H_FP     = 110,
    parameter int H_SYNC   = 40,
    parameter int H_BP     = 220,
    parameter int V_ACTIVE = 720,
    parameter int V_FP     = 5,
    parameter int V_SYNC   = 5,
    parameter int V_BP     = 20
) (
    input  logic                          clk_pixel,
    input  logic                          recent_reset,
    input  logic [tracker_pkg::PIXEL_W-1:0] pixel_rgb,     // frame-buffer pixel for raster t
    input  logic [tracker_pkg::PIXEL_W-1:0] pixel_ycc,
    input  logic [2:0]                    channel_sel,
    input  logic [3:0]                    lower_nib,
    input  logic [3:0]                    upper_nib,
    input  logic [1:0]                    bg_sel,
    input  logic                          crosshair_en,
    output logic [tracker_pkg::X_W-1:0]     hcount,        // all of these at t+3
    output logic [tracker_pkg::Y_W-1:0]     vcount,
    output logic                          hsync,
    output logic                          vsync,
    output logic                          active_draw,
    output logic [tracker_pkg::PIXEL_W-1:0] pixel_out,
    output logic [tracker_pkg::X_W-1:0]     x_com,
    output logic [tracker_pkg::Y_W-1:0]     y_com,
    output logic                          com_valid
);
    import tracker_pkg::*;

    // raster at t
    logic [X_W-1:0]     vt_hcount;
    logic [Y_W-1:0]     vt_vcount;
    logic               vt_hsync, vt_vsync, vt_active_draw, vt_new_frame;

    // stage 2 at t+2
    logic [X_W-1:0]     s2_hcount;
    logic [Y_W-1:0]     s2_vcount;
    logic               s2_hsync, s2_vsync, s2_active_draw, s2_new_frame;
    logic [PIXEL_W-1:0] s2_rgb;
    logic [COLOR_W-1:0] s2_channel;
    logic               s2_mask;

    video_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) video_timing_i (
        .clk_pixel(clk_pixel), .recent_reset(recent_reset),
        .hcount(vt_hcount), .vcount(vt_vcount), .hsync(vt_hsync), .vsync(vt_vsync),
        .active_draw(vt_active_draw), .new_frame(vt_new_frame)
    );

    channel_mask channel_mask_i (
        .clk_pixel(clk_pixel), .recent_reset(recent_reset),
        .hcount(vt_hcount), .vcount(vt_vcount), .hsync(vt_hsync), .vsync(vt_vsync),
        .active_draw(vt_active_draw), .new_frame(vt_new_frame),
        .pixel_rgb(pixel_rgb), .pixel_ycc(pixel_ycc), .channel_sel(channel_sel),
        .lower_nib(lower_nib), .upper_nib(upper_nib),
        .s2_hcount(s2_hcount), .s2_vcount(s2_vcount), .s2_hsync(s2_hsync),
        .s2_vsync(s2_vsync), .s2_active_draw(s2_active_draw), .s2_new_frame(s2_new_frame),
        .s2_rgb(s2_rgb), .s2_channel(s2_channel), .s2_mask(s2_mask)
    );

    centroid #(
        .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)
    ) centroid_i (
        .clk_pixel(clk_pixel), .recent_reset(recent_reset),
        .x_in(s2_hcount), .y_in(s2_vcount), .active_draw(s2_active_draw),
        .mask(s2_mask), .tally(s2_new_frame),
        .x_com(x_com), .y_com(y_com), .com_valid(com_valid)
    );

    overlay_mux overlay_mux_i (
        .clk_pixel(clk_pixel), .recent_reset(recent_reset),
        .s2_hcount(s2_hcount), .s2_vcount(s2_vcount), .s2_hsync(s2_hsync),
        .s2_vsync(s2_vsync), .s2_active_draw(s2_active_draw),
        .s2_rgb(s2_rgb), .s2_channel(s2_channel), .s2_mask(s2_mask),
        .x_com(x_com), .y_com(y_com), .bg_sel(bg_sel), .crosshair_en(crosshair_en),
        .hcount_out(hcount), .vcount_out(vcount), .hsync_out(hsync), .vsync_out(vsync),
        .active_draw_out(active_draw), .pixel_out(pixel_out)
    );

endmodule

// ==== verification/tracker_chk.sv ====
`timescale 1ns/1ps

module tracker_chk #(
    parameter int H_TOTAL = 1650          // cycles per line
) (
    input logic                            clk_pixel,
    input logic                            recent_reset,
    input logic [tracker_pkg::X_W-1:0]     hcount,
    input logic                            hsync,
    input logic                            vsync,
    input logic                            active_draw,
    input logic [tracker_pkg::PIXEL_W-1:0] pixel_out,
    input logic                            com_valid
);

    // centre of mass result is a one-cycle strobe
    com_single: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        com_valid |=> !com_valid)
        else $error("com_valid high for two cycles");

    // output flags come out of reset low
    reset_quiet: assert property (@(posedge clk_pixel)
        recent_reset |=> !hsync && !vsync && !active_draw)
        else $error("sync or active_draw high during reset");

    blank_black: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        !active_draw |-> (pixel_out == '0))
        else $error("pixel_out not black outside active draw");

    h_range: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        hcount < H_TOTAL)
        else $error("hcount beyond line length");

endmodule

bind tracker_top tracker_chk #(
    .H_TOTAL(H_ACTIVE + H_FP + H_SYNC + H_BP)
) tracker_chk_i (
    .clk_pixel(clk_pixel), .recent_reset(recent_reset), .hcount(hcount),
    .hsync(hsync), .vsync(vsync), .active_draw(active_draw),
    .pixel_out(pixel_out), .com_valid(com_valid)
);

// ==== verification/tracker_tb.sv ====
`timescale 1ns/1ps

module tracker_tb;
    import tracker_pkg::*;

    // small raster, 48 cycles per line and 24 lines per frame
    localparam int H_ACTIVE    = 32;
    localparam int H_FP        = 4;
    localparam int H_SYNC      = 4;
    localparam int H_BP        = 8;
    localparam int V_ACTIVE    = 16;
    localparam int V_FP        = 2;
    localparam int V_SYNC      = 2;
    localparam int V_BP        = 4;
    localparam int H_TOTAL     = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL     = V_ACTIVE + V_FP + V_SYNC + V_BP;
    localparam int NUM_FRAMES  = 33;      // frame 0 is cut short by reset
    localparam int WATCHDOG_NS = (NUM_FRAMES + 2) * H_TOTAL * V_TOTAL * 4;

    logic               clk_pixel;
    logic               recent_reset;
    logic [PIXEL_W-1:0] pixel_rgb, pixel_ycc;
    logic [2:0]         channel_sel;
    logic [3:0]         lower_nib, upper_nib;
    logic [1:0]         bg_sel;
    logic               crosshair_en;
    logic [X_W-1:0]     hcount, x_com;
    logic [Y_W-1:0]     vcount, y_com;
    logic               hsync, vsync, active_draw, com_valid;
    logic [PIXEL_W-1:0] pixel_out;

    logic [PIXEL_W-1:0] rgb_q[$];         // pixels in flight, oldest first
    logic [PIXEL_W-1:0] ycc_q[$];
    int                 checks, errors, frame_errs;

    tracker_top #(
        .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) tracker_top_i (.*);

    always #2 clk_pixel = ~clk_pixel;     // 4 ns period

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            frame_errs++;
            $display("error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    // selectors sweep every bg and channel code, thresholds and crosshair random
    task automatic apply_controls(input int k);
        bg_sel       = 2'(k % 4);
        channel_sel  = 3'((k / 4) % 8);
        lower_nib    = 4'($urandom);
        upper_nib    = 4'($urandom);
        crosshair_en = 1'($urandom);
    endtask

    function automatic logic [COLOR_W-1:0] pick_channel(input logic [2:0] sel,
            input logic [PIXEL_W-1:0] rgb, input logic [PIXEL_W-1:0] ycc);
        case (sel)
            SEL_RED:   return rgb[23:16];
            SEL_GREEN: return rgb[15:8];
            SEL_BLUE:  return rgb[7:0];
            SEL_Y:     return ycc[23:16];
            SEL_CR:    return ycc[15:8];
            SEL_CB:    return ycc[7:0];
            default:   return '0;         // 011 and 111
        endcase
    endfunction

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish %0d frames in time", NUM_FRAMES);
        $display("Verification failed");
        $finish;
    end

    initial begin
        logic [PIXEL_W-1:0] cur_rgb, cur_ycc, exp_pix;
        logic [COLOR_W-1:0] ch;
        logic               m, act, started;
        int                 mh, mv, cyc, ctl_frame, frames_done, pulses, exp_pulses;
        int                 x_sum, y_sum, n_sum, xc, yc, rep_sel, rep_bg, rep_n;
        clk_pixel    = 1'b0;
        recent_reset = 1'b1;
        pixel_rgb    = '0;
        pixel_ycc    = '0;
        {checks, errors, frame_errs} = '0;
        {mh, mv, cyc, ctl_frame, frames_done, pulses, exp_pulses} = '0;
        {x_sum, y_sum, n_sum, xc, yc, rep_sel, rep_bg, rep_n} = '0;
        {cur_rgb, cur_ycc} = '0;
        started = 1'b0;
        void'($urandom(11913));
        apply_controls(0);
        while (frames_done < NUM_FRAMES) begin
            @(negedge clk_pixel);
            if (cyc == 9) recent_reset = 1'b0;    // 10 rising edges seen by now
            cyc++;
            if (rgb_q.size() == 3) begin          // pixel driven three cycles ago
                cur_rgb = rgb_q.pop_front();
                cur_ycc = ycc_q.pop_front();
            end
            if (started) begin
                mh++;
                if (mh == H_TOTAL) begin
                    mh = 0;
                    mv = (mv == V_TOTAL - 1) ? 0 : mv + 1;
                end
            end else if (hcount == 1) begin       // first position with valid flags
                started = 1'b1;
                mh = 1;
                mv = 0;
            end
            if (started) begin
                act = (mh < H_ACTIVE) && (mv < V_ACTIVE);
                check_value("hcount", hcount, mh);
                check_value("vcount", vcount, mv);
                check_value("hsync", hsync,
                            (mh >= H_ACTIVE + H_FP) && (mh < H_ACTIVE + H_FP + H_SYNC));
                check_value("vsync", vsync,
                            (mv >= V_ACTIVE + V_FP) && (mv < V_ACTIVE + V_FP + V_SYNC));
                check_value("active_draw", active_draw, act);
                ch = pick_channel(channel_sel, cur_rgb, cur_ycc);
                m  = (ch >= {lower_nib, 4'h0}) && (ch <= {upper_nib, 4'h0});  // inclusive
                case (bg_sel)
                    BG_CAMERA:  exp_pix = cur_rgb;
                    BG_CHANNEL: exp_pix = {3{ch}};
                    BG_MASK:    exp_pix = m ? {PIXEL_W{1'b1}} : '0;
                    default:    exp_pix = m ? MAGENTA : {3{ch}};
                endcase
                if (crosshair_en && (mh == xc || mv == yc)) exp_pix = {PIXEL_W{1'b1}};
                if (!act) exp_pix = '0;
                check_value("pixel_out", pixel_out, exp_pix);
                if (act && m) begin
                    x_sum += mh;
                    y_sum += mv;
                    n_sum++;
                end
                if (com_valid) pulses++;              // counted over the whole frame
                if (mh == 0 && mv == V_ACTIVE) begin  // frame over, settle the centre
                    exp_pulses = (n_sum != 0);
                    if (n_sum != 0) begin
                        xc = x_sum / n_sum;
                        yc = y_sum / n_sum;
                    end
                    {rep_sel, rep_bg, rep_n} = {32'(channel_sel), 32'(bg_sel), n_sum};
                    {x_sum, y_sum, n_sum} = '0;
                end
                if (mh == 0 && mv == 0) begin         // result due before first pixel
                    check_value("com_valid pulse count", pulses, exp_pulses);
                    check_value("x_com", x_com, xc);
                    check_value("y_com", y_com, yc);
                    $display("frame %0d: sel %0d bg %0d masked %0d, %0d errors",
                             frames_done, rep_sel, rep_bg, rep_n, frame_errs);
                    frames_done++;
                    frame_errs = 0;
                    pulses = 0;
                end
                if (mh == 0 && mv == V_ACTIVE + V_FP) begin  // output vsync just rose
                    ctl_frame++;
                    apply_controls(ctl_frame);
                end
            end
            pixel_rgb = PIXEL_W'($urandom);
            pixel_ycc = PIXEL_W'($urandom);
            rgb_q.push_back(pixel_rgb);
            ycc_q.push_back(pixel_ycc);
        end
        $display("%0d frames, %0d checks, %0d errors", frames_done, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
logic/tracker_pkg.sv
logic/video_timing.sv
logic/channel_mask.sv
logic/centroid.sv
logic/overlay_mux.sv
logic/tracker_top.sv
verification/tracker_chk.sv
verification/tracker_tb.sv

// ==== Bender.yml ====
package:
  name: tracker

dependencies: {}

sources:
  - files:
      - logic/tracker_pkg.sv
      - logic/video_timing.sv
      - logic/channel_mask.sv
      - logic/centroid.sv
      - logic/overlay_mux.sv
      - logic/tracker_top.sv
  - target: test
    files:
      - verification/tracker_chk.sv
      - verification/tracker_tb.sv
